// ==== vlog.f ====
src/pkg_eu_ops.sv
src/pkg_dtypes.sv
src/operand_if.sv
src/eu_iqueue.sv
src/eu_result_store.sv
src/eu_prepop.sv
src/eu_alu.sv
src/exec_unit.sv
test/tb_exec_unit.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -f vlog.f --top-module tb_exec_unit -o tb_exec_unit \
  && ./obj_dir/tb_exec_unit > sim.log 2>&1 \
  || { echo "build or simulation error"; exit 1; }
grep -qx "SIMULATION PASSED" sim.log \
  && echo "run passed" \
  || { cat sim.log; exit 1; }

// ==== test/tb_exec_unit.sv ====
module tb_exec_unit import pkg_dtypes::*, pkg_eu_ops::*; ();

  localparam int         HALF_PERIOD    = 50;
  localparam int         RESET_CYCLES   = 10;
  localparam int         TIMEOUT_CYCLES = 4000;
  localparam type_eu_idx TB_EU_IDX      = 2'd0;

  logic               clk;
  logic               reset_n;
  logic               instr_valid_i;
  type_iqueue_entry   instr_i;
  logic               instr_ready_o;
  logic               fop0_req_o;
  type_exec_unit_addr fop0_addr_o;
  type_exec_unit_data fop0_data_i;
  logic               fop0_success_i;
  logic               fop1_req_o;
  type_exec_unit_addr fop1_addr_o;
  type_exec_unit_data fop1_data_i;
  logic               fop1_success_i;
  logic               res_valid_o;
  type_uid            res_uid_o;
  type_exec_unit_data res_data_o;

  string              cur_test;
  int                 value_errors;
  int                 timing_errors;
  int                 other_errors;
  int                 cycle_count;
  int                 n_accepted;
  int                 res_count;
  logic               issue_seen;
  logic               full_seen;
  type_exec_unit_data local_val [RS_ENTRIES];
  type_uid            exp_uid [$];
  type_exec_unit_data exp_data [$];

  exec_unit #(.EU_IDX(TB_EU_IDX)) dut0 (.*);

  initial clk = 1'b0;
  always #HALF_PERIOD clk = ~clk;

  // data of another unit by the fixed address rule
  function automatic type_exec_unit_data foreign_value(input type_exec_unit_addr addr);
    return type_exec_unit_data'(int'(addr[5:4]) * 4096 + int'(addr[3:0]) * 17 + 5);
  endfunction

  // other units answer with a 1-in-3 chance of success per cycle
  always @(posedge clk) begin
    #1;
    fop0_success_i = fop0_req_o && ($urandom % 3 == 0);
    // junk data outside a success cycle
    fop0_data_i    = fop0_success_i ? foreign_value(fop0_addr_o)
                                    : ~foreign_value(fop0_addr_o);
    fop1_success_i = fop1_req_o && ($urandom % 3 == 0);
    fop1_data_i    = fop1_success_i ? foreign_value(fop1_addr_o)
                                    : ~foreign_value(fop1_addr_o);
  end

  function automatic type_exec_unit_data operand_value(input logic isreg,
                                                       input type_exec_unit_data op);
    type_exec_unit_addr addr;
    addr = op[5:0];
    if (!isreg) return op;
    if (addr[5:4] == TB_EU_IDX) return local_val[addr[3:0]];
    return foreign_value(addr);
  endfunction

  function automatic type_exec_unit_data expected_result(input eu_opcode_e opcode,
                                                         input type_exec_unit_data a,
                                                         input type_exec_unit_data b);
    case (opcode)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      default: return a ^ b;
    endcase
  endfunction

  function automatic type_exec_unit_data reg_op(input int idx, input int uid);
    return type_exec_unit_data'({idx[1:0], uid[3:0]});
  endfunction

  function automatic type_iqueue_entry make_instr(input eu_opcode_e opcode, input int dst,
      input logic r0, input type_exec_unit_data op0, input logic r1,
      input type_exec_unit_data op1);
    type_iqueue_entry e;
    e.opcode    = opcode;
    e.dst       = type_uid'(dst);
    e.op0_isreg = r0;
    e.op0       = op0;
    e.op1_isreg = r1;
    e.op1       = op1;
    return e;
  endfunction

  // holds valid until the queue takes it and then records the expected result
  task automatic send(input type_iqueue_entry e);
    logic               taken;
    type_exec_unit_data res;
    taken         = 1'b0;
    instr_valid_i = 1'b1;
    instr_i       = e;
    while (!taken) begin
      @(posedge clk);
      taken = instr_ready_o;
      if (!taken) full_seen = 1'b1;
      #1;
    end
    instr_valid_i = 1'b0;
    res = expected_result(e.opcode, operand_value(e.op0_isreg, e.op0),
                          operand_value(e.op1_isreg, e.op1));
    exp_uid.push_back(e.dst);
    exp_data.push_back(res);
    local_val[e.dst] = res;
    n_accepted++;
  endtask

  task automatic apply_reset(input string name);
    cur_test = name;
    reset_n  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n    = 1'b1;
    n_accepted = 0;
    res_count  = 0;
    full_seen  = 1'b0;
    for (int i = 0; i < RS_ENTRIES; i++) local_val[i] = '0;
  endtask

  task automatic finish_test();
    while (exp_uid.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (2) @(posedge clk);
    #1;
    if (res_count != n_accepted) begin
      other_errors++;
      $display("%s: got %0d results for %0d accepted instructions", cur_test, res_count,
               n_accepted);
    end
  endtask

  task automatic check_level(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("CHECK FAILED %s: %s expected %b actual %b", cur_test, what, expected, actual);
    end
  endtask

  task automatic random_operand(input int pos, output logic isreg,
                                output type_exec_unit_data op);
    int kind;
    kind  = (pos == 0) ? 0 : int'($urandom % 3);
    isreg = (kind != 0);
    if (kind == 0) op = 16'($urandom);
    else if (kind == 1) op = reg_op(1 + int'($urandom % 3), int'($urandom % 16));
    else op = reg_op(0, int'($urandom % pos));
  endtask

  // result strobe follows issue by one cycle and values come in program order
  always @(posedge clk) begin
    type_uid            e_uid;
    type_exec_unit_data e_data;
    if (reset_n) begin
      if (res_valid_o !== issue_seen) begin
        timing_errors++;
        $display("%s: result strobe did not come one cycle after issue", cur_test);
      end
      if (res_valid_o) begin
        res_count++;
        if (exp_uid.size() == 0) begin
          other_errors++;
          $display("%s: result arrived with no instruction outstanding", cur_test);
        end else begin
          e_uid  = exp_uid.pop_front();
          e_data = exp_data.pop_front();
          if (res_uid_o !== e_uid) begin
            value_errors++;
            $display("CHECK FAILED %s: uid expected %h actual %h", cur_test, e_uid, res_uid_o);
          end
          if (res_data_o !== e_data) begin
            value_errors++;
            $display("CHECK FAILED %s: data expected %h actual %h", cur_test, e_data,
                     res_data_o);
          end
        end
      end
    end
    issue_seen = reset_n && dut0.issue;
  end

  task automatic print_counts();
    $display("errors: value %0d, timing %0d, other %0d", value_errors, timing_errors,
             other_errors);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      print_counts();
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    type_iqueue_entry   e;
    logic               r0;
    logic               r1;
    type_exec_unit_data op0;
    type_exec_unit_data op1;
    void'($urandom(28));
    reset_n        = 1'b0;
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    fop0_data_i    = '0;
    fop0_success_i = 1'b0;
    fop1_data_i    = '0;
    fop1_success_i = 1'b0;
    issue_seen     = 1'b0;
    value_errors   = 0;
    timing_errors  = 0;
    other_errors   = 0;
    cycle_count    = 0;

    apply_reset("reset");
    check_level("res_valid_o", 1'b0, res_valid_o);
    check_level("fop0_req_o", 1'b0, fop0_req_o);
    check_level("fop1_req_o", 1'b0, fop1_req_o);
    check_level("instr_ready_o", 1'b1, instr_ready_o);

    apply_reset("immediates");
    for (int i = 0; i < 8; i++) begin
      send(make_instr(eu_opcode_e'(2'(i)), i, 1'b0, 16'($urandom), 1'b0, 16'($urandom)));
    end
    finish_test();

    apply_reset("local_deps");
    send(make_instr(OP_ADD, 0, 1'b0, 16'($urandom), 1'b0, 16'($urandom)));
    send(make_instr(OP_SUB, 1, 1'b1, reg_op(0, 0), 1'b0, 16'h0101));
    // uid 1 is still in flight here
    send(make_instr(OP_XOR, 2, 1'b1, reg_op(0, 1), 1'b1, reg_op(0, 0)));
    send(make_instr(OP_AND, 3, 1'b1, reg_op(0, 2), 1'b0, 16'h0ff0));
    send(make_instr(OP_ADD, 4, 1'b1, reg_op(0, 3), 1'b1, reg_op(0, 3)));
    finish_test();

    apply_reset("foreign");
    for (int i = 0; i < 6; i++) begin
      op0 = reg_op(1 + int'($urandom % 3), int'($urandom % 16));
      r1  = (i % 3 != 1);
      if (i % 3 == 0) op1 = reg_op(1 + int'($urandom % 3), int'($urandom % 16));
      else if (i % 3 == 1) op1 = 16'($urandom);
      else op1 = reg_op(0, 0);
      send(make_instr(eu_opcode_e'(2'(i)), i, 1'b1, op0, r1, op1));
    end
    finish_test();

    apply_reset("burst");
    for (int i = 0; i < 10; i++) begin
      random_operand(i, r0, op0);
      random_operand(i, r1, op1);
      e = make_instr(eu_opcode_e'(2'($urandom)), i, r0, op0, r1, op1);
      send(e);
    end
    if (!full_seen) begin
      other_errors++;
      $display("burst: the queue never reported full");
    end
    finish_test();

    print_counts();
    if (value_errors + timing_errors + other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== src/exec_unit.sv ====
module exec_unit import pkg_dtypes::*; #(
  parameter type_eu_idx EU_IDX = 0
) (
  input  logic               clk,
  input  logic               reset_n,

  input  logic               instr_valid_i,
  input  type_iqueue_entry   instr_i,
  output logic               instr_ready_o,

  output logic               fop0_req_o,
  output type_exec_unit_addr fop0_addr_o,
  input  type_exec_unit_data fop0_data_i,
  input  logic               fop0_success_i,
  output logic               fop1_req_o,
  output type_exec_unit_addr fop1_addr_o,
  input  type_exec_unit_data fop1_data_i,
  input  logic               fop1_success_i,

  output logic               res_valid_o,
  output type_uid            res_uid_o,
  output type_exec_unit_data res_data_o
);

  operand_if local_ops ();
  operand_if foreign_ops ();
  operand_if ready_ops ();

  type_iqueue_entry current_instr;
  logic             op0_isreg;
  logic             op0_isforeign;
  logic             op1_isreg;
  logic             op1_isforeign;
  logic             issue;

  // other units answer through the foreign ports
  assign foreign_ops.op0_data    = fop0_data_i;
  assign foreign_ops.op0_success = fop0_success_i;
  assign foreign_ops.op1_data    = fop1_data_i;
  assign foreign_ops.op1_success = fop1_success_i;

  eu_iqueue #(.EU_IDX(EU_IDX)) iqueue0 (
    .clk, .reset_n,
    .instr_valid_i, .instr_i, .instr_ready_o,
    .ops             (ready_ops),
    .current_instr_o (current_instr),
    .op0_isreg_o     (op0_isreg),
    .op0_isforeign_o (op0_isforeign),
    .op1_isreg_o     (op1_isreg),
    .op1_isforeign_o (op1_isforeign),
    .issue_o         (issue),
    .fop0_req_o, .fop0_addr_o,
    .fop1_req_o, .fop1_addr_o
  );

  // results written back for local dependencies
  eu_result_store store0 (
    .clk, .reset_n,
    .wr_valid_i      (res_valid_o),
    .wr_uid_i        (res_uid_o),
    .wr_data_i       (res_data_o),
    .current_instr_i (current_instr),
    .rd              (local_ops)
  );

  eu_prepop prepop0 (
    .clk, .reset_n,
    .foreign         (foreign_ops),
    .local_ops       (local_ops),
    .current_instr_i (current_instr),
    .op0_isreg_i     (op0_isreg),
    .op0_isforeign_i (op0_isforeign),
    .op1_isreg_i     (op1_isreg),
    .op1_isforeign_i (op1_isforeign),
    .ready           (ready_ops)
  );

  eu_alu alu0 (
    .clk, .reset_n,
    .issue_i         (issue),
    .current_instr_i (current_instr),
    .ops             (ready_ops),
    .res_valid_o, .res_uid_o, .res_data_o
  );

endmodule

// ==== src/eu_alu.sv ====
module eu_alu import pkg_dtypes::*, pkg_eu_ops::*; (
  input  logic               clk,
  input  logic               reset_n,

  input  logic               issue_i,
  input  type_iqueue_entry   current_instr_i,
  operand_if.sink            ops,

  output logic               res_valid_o,
  output type_uid            res_uid_o,
  output type_exec_unit_data res_data_o
);

  type_exec_unit_data result;

  // add and sub wrap at the data width
  always_comb begin
    result = '0;
    case (current_instr_i.opcode)
      OP_ADD:  result = ops.op0_data + ops.op1_data;
      OP_SUB:  result = ops.op0_data - ops.op1_data;
      OP_AND:  result = ops.op0_data & ops.op1_data;
      OP_XOR:  result = ops.op0_data ^ ops.op1_data;
      default: result = '0;
    endcase
  end

  // one-cycle strobe, results are never stalled
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= issue_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i) begin
      res_uid_o  <= current_instr_i.dst;
      res_data_o <= result;
    end
  end

endmodule

// ==== src/eu_prepop.sv ====
module eu_prepop import pkg_dtypes::*; (
  input  logic             clk,
  input  logic             reset_n,

  operand_if.sink          foreign,
  operand_if.sink          local_ops,

  input  type_iqueue_entry current_instr_i,
  input  logic             op0_isreg_i,
  input  logic             op0_isforeign_i,
  input  logic             op1_isreg_i,
  input  logic             op1_isforeign_i,

  operand_if.source        ready
);

  // single entry for the operand that arrived first
  logic               hold_valid;
  logic               hold_opx;
  type_exec_unit_data hold_data;
  logic               hold_load;

  type_exec_unit_data src0_data;
  type_exec_unit_data src1_data;
  logic               src0_ok;
  logic               src1_ok;
  logic               both_ok;

  // pick local or foreign source per operand
  always_comb begin
    if (op0_isforeign_i) begin
      src0_data = foreign.op0_data;
      src0_ok   = op0_isreg_i & foreign.op0_success;
    end else begin
      src0_data = local_ops.op0_data;
      src0_ok   = op0_isreg_i & local_ops.op0_success;
    end
    if (op1_isforeign_i) begin
      src1_data = foreign.op1_data;
      src1_ok   = op1_isreg_i & foreign.op1_success;
    end else begin
      src1_data = local_ops.op1_data;
      src1_ok   = op1_isreg_i & local_ops.op1_success;
    end
  end

  // priority: immediate, then held value, then live source
  always_comb begin
    if (!op0_isreg_i) begin
      ready.op0_data    = current_instr_i.op0;
      ready.op0_success = 1'b1;
    end else if (hold_valid && !hold_opx) begin
      ready.op0_data    = hold_data;
      ready.op0_success = 1'b1;
    end else begin
      ready.op0_data    = src0_data;
      ready.op0_success = src0_ok;
    end

    if (!op1_isreg_i) begin
      ready.op1_data    = current_instr_i.op1;
      ready.op1_success = 1'b1;
    end else if (hold_valid && hold_opx) begin
      ready.op1_data    = hold_data;
      ready.op1_success = 1'b1;
    end else begin
      ready.op1_data    = src1_data;
      ready.op1_success = src1_ok;
    end
  end

  assign both_ok = ready.op0_success & ready.op1_success;

  // exactly one register operand showed up and the other is still missing
  assign hold_load = !both_ok && !hold_valid && (src0_ok ^ src1_ok);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      hold_valid <= 1'b0;
      hold_opx   <= 1'b0;
    end else if (both_ok) begin
      // instruction issues this cycle, free the entry for the next one
      hold_valid <= 1'b0;
    end else if (hold_load) begin
      hold_valid <= 1'b1;
      hold_opx   <= src1_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (hold_load) begin
      hold_data <= src0_ok ? src0_data : src1_data;
    end
  end

endmodule

// ==== src/eu_result_store.sv ====
module eu_result_store import pkg_dtypes::*, pkg_eu_ops::*; (
  input  logic               clk,
  input  logic               reset_n,

  // write port from the ALU
  input  logic               wr_valid_i,
  input  type_uid            wr_uid_i,
  input  type_exec_unit_data wr_data_i,

  input  type_iqueue_entry   current_instr_i,
  operand_if.source          rd
);

  type_exec_unit_data    data_mem [RS_ENTRIES];
  logic [RS_ENTRIES-1:0] valid;
  type_uid               rd0_uid;
  type_uid               rd1_uid;

  // only the uid part matters locally, the unit index is checked in the iqueue
  assign rd0_uid = uid_of(addr_of(current_instr_i.op0));
  assign rd1_uid = uid_of(addr_of(current_instr_i.op1));

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid <= '0;
    end else if (wr_valid_i) begin
      valid[wr_uid_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid_i) begin
      data_mem[wr_uid_i] <= wr_data_i;
    end
  end

  // no write bypass, a new result is visible the cycle after it is written
  assign rd.op0_data    = data_mem[rd0_uid];
  assign rd.op0_success = valid[rd0_uid];
  assign rd.op1_data    = data_mem[rd1_uid];
  assign rd.op1_success = valid[rd1_uid];

endmodule

// ==== src/eu_iqueue.sv ====
module eu_iqueue import pkg_dtypes::*, pkg_eu_ops::*; #(
  parameter type_eu_idx EU_IDX = '0
) (
  input  logic               clk,
  input  logic               reset_n,

  input  logic               instr_valid_i,
  input  type_iqueue_entry   instr_i,
  output logic               instr_ready_o,

  // successes coming back from prepop
  operand_if.sink            ops,

  output type_iqueue_entry   current_instr_o,
  output logic               op0_isreg_o,
  output logic               op0_isforeign_o,
  output logic               op1_isreg_o,
  output logic               op1_isforeign_o,
  output logic               issue_o,

  output logic               fop0_req_o,
  output type_exec_unit_addr fop0_addr_o,
  output logic               fop1_req_o,
  output type_exec_unit_addr fop1_addr_o
);

  type_iqueue_entry    entries [IQ_DEPTH];
  logic [IQ_PTR_W-1:0] head;
  logic [IQ_PTR_W-1:0] tail;
  logic [IQ_PTR_W:0]   count;
  logic                head_valid;
  logic                push;
  type_exec_unit_addr  op0_addr;
  type_exec_unit_addr  op1_addr;

  assign head_valid    = (count != '0);
  assign instr_ready_o = (count != (IQ_PTR_W+1)'(IQ_DEPTH));
  assign push          = instr_valid_i & instr_ready_o;

  // empty queue looks like an instruction with two immediates
  assign current_instr_o = head_valid ? entries[head] : '0;

  assign op0_addr = addr_of(current_instr_o.op0);
  assign op1_addr = addr_of(current_instr_o.op1);

  assign op0_isreg_o     = current_instr_o.op0_isreg;
  assign op1_isreg_o     = current_instr_o.op1_isreg;
  assign op0_isforeign_o = op0_isreg_o & (idx_of(op0_addr) != EU_IDX);
  assign op1_isforeign_o = op1_isreg_o & (idx_of(op1_addr) != EU_IDX);

  assign issue_o = head_valid & ops.op0_success & ops.op1_success;

  assign fop0_req_o  = op0_isforeign_o;
  assign fop0_addr_o = op0_addr;
  assign fop1_req_o  = op1_isforeign_o;
  assign fop1_addr_o = op1_addr;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      // issue is the pop
      if (issue_o) begin
        head <= head + 1'b1;
      end
      case ({push, issue_o})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[tail] <= instr_i;
    end
  end

endmodule

// ==== src/operand_if.sv ====
interface operand_if import pkg_dtypes::*; ();

  type_exec_unit_data op0_data;
  logic               op0_success;
  type_exec_unit_data op1_data;
  logic               op1_success;

  modport source (
    output op0_data, op0_success,
    output op1_data, op1_success
  );

  modport sink (
    input op0_data, op0_success,
    input op1_data, op1_success
  );

endinterface

// ==== src/pkg_dtypes.sv ====
package pkg_dtypes;
  import pkg_eu_ops::*;

  localparam int DATA_W   = 16;
  localparam int EU_IDX_W = 2;
  localparam int UID_W    = 4;
  localparam int ADDR_W   = EU_IDX_W + UID_W;

  typedef logic [DATA_W-1:0]   type_exec_unit_data;
  typedef logic [EU_IDX_W-1:0] type_eu_idx;
  typedef logic [UID_W-1:0]    type_uid;
  // unit index on top, uid below
  typedef logic [ADDR_W-1:0]   type_exec_unit_addr;

  // op0/op1 hold an immediate, or an address in the low bits when isreg is set
  typedef struct packed {
    eu_opcode_e         opcode;
    type_uid            dst;
    logic               op0_isreg;
    logic               op1_isreg;
    type_exec_unit_data op0;
    type_exec_unit_data op1;
  } type_iqueue_entry;

  function automatic type_exec_unit_addr addr_of(type_exec_unit_data operand);
    return operand[ADDR_W-1:0];
  endfunction

  function automatic type_eu_idx idx_of(type_exec_unit_addr addr);
    return addr[ADDR_W-1:UID_W];
  endfunction

  function automatic type_uid uid_of(type_exec_unit_addr addr);
    return addr[UID_W-1:0];
  endfunction

endpackage

// ==== src/pkg_eu_ops.sv ====
package pkg_eu_ops;

  // instruction queue depth, power of two so the pointers wrap on their own
  localparam int IQ_DEPTH = 4;
  localparam int IQ_PTR_W = $clog2(IQ_DEPTH);

  // one result-store entry per uid
  localparam int RS_ENTRIES = 16;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_AND = 2'd2,
    OP_XOR = 2'd3
  } eu_opcode_e;

endpackage
